/* logic/arcade_consts.svh */
// Input block constants
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// ==================================================
// Widths
// ==================================================
`define DL_ADDR_W          25
`define CTRL_W             10
`define JOY_W              32
`define JOY_COIN_BIT       10

// Download stream indices
`define DL_INDEX_ROM       8'd0
`define DL_INDEX_GAME      8'd1
`define DL_INDEX_DIP       8'd254

// ==================================================
// Keyboard scan codes
// ==================================================
`define KEY_P1_UP          8'h75
`define KEY_P1_DOWN        8'h72
`define KEY_P1_LEFT        8'h6B
`define KEY_P1_RIGHT       8'h74
`define KEY_P1_COIN        8'h76
`define KEY_P1_COIN_ALT    8'h2E
`define KEY_P1_FIRE_A      8'h14
`define KEY_P1_FIRE_B      8'h11
`define KEY_P1_FIRE_C      8'h29
`define KEY_P1_FIRE_D      8'h12
`define KEY_P1_FIRE_E      8'h1A
`define KEY_SHIFT          8'h22
`define KEY_P2_COIN        8'h36
`define KEY_P2_UP          8'h2D
`define KEY_P2_DOWN        8'h2B
`define KEY_P2_LEFT        8'h23
`define KEY_P2_RIGHT       8'h34
`define KEY_P2_FIRE_A      8'h1C
`define KEY_P2_FIRE_B      8'h1B
`define KEY_P2_FIRE_C      8'h21
`define KEY_P2_FIRE_D      8'h1D

// Late reset pulse counter length
`define RESET_PULSE_CYCLES 16

`endif

/* logic/arcade_inputs.sv */
// Input block top level
`include "arcade_consts.svh"

module arcade_inputs (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic [10:0]           ps2_key,
	input  logic [`JOY_W-1:0]     joy_1,
	input  logic [`JOY_W-1:0]     joy_2,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic [7:0]            ioctl_index,
	input  logic [`DL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  user_reset,
	output logic [7:0]            input_0,
	output logic [7:0]            input_1,
	output logic [7:0]            input_2,
	output logic [7:0]            input_3,
	output logic [7:0]            input_4,
	output logic                  landscape,
	output logic                  game_reset
);
	import arcade_pkg::*;

	ctrl_t      controls;
	logic       coin;
	game_e      game;
	logic [7:0] dip_0;
	logic [7:0] dip_1;
	logic       rom_loaded;

	// ==================================================
	// Controls and setup
	// ==================================================
	player_controls u_player_controls (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.ps2_key  (ps2_key),
		.joy_1    (joy_1),
		.joy_2    (joy_2),
		.controls (controls),
		.coin     (coin)
	);

	setup_loader u_setup_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.game           (game),
		.dip_0          (dip_0),
		.dip_1          (dip_1),
		.rom_loaded     (rom_loaded)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.user_reset (user_reset),
		.rom_loaded (rom_loaded),
		.game_reset (game_reset)
	);

	// Ports seen by the game CPU
	input_port_map u_input_port_map (
		.game      (game),
		.controls  (controls),
		.coin      (coin),
		.dip_0     (dip_0),
		.dip_1     (dip_1),
		.input_0   (input_0),
		.input_1   (input_1),
		.input_2   (input_2),
		.input_3   (input_3),
		.input_4   (input_4),
		.landscape (landscape)
	);

endmodule

/* logic/arcade_pkg.sv */
// Input block types
package arcade_pkg;

	// Game selected by the download stream
	typedef enum logic [1:0] {
		GAME_SPYHNT = 2'd0,
		GAME_TURBO  = 2'd1,
		GAME_CRATER = 2'd2,
		GAME_NONE   = 2'd3
	} game_e;

	// One player's controls, bit 0 is right
	typedef struct packed {
		logic shift;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} ctrl_t;

endpackage

/* logic/input_port_map.sv */
// Per-game input port mapping
module input_port_map (
	input  arcade_pkg::game_e game,
	input  arcade_pkg::ctrl_t controls,
	input  logic              coin,
	input  logic [7:0]        dip_0,
	input  logic [7:0]        dip_1,
	output logic [7:0]        input_0,
	output logic [7:0]        input_1,
	output logic [7:0]        input_2,
	output logic [7:0]        input_3,
	output logic [7:0]        input_4,
	output logic              landscape
);
	import arcade_pkg::*;

	logic service;

	assign service = dip_1[0];

	// ==================================================
	// Active-low port mapping
	// ==================================================
	always_comb begin
		// Idle ports, steering and spinner read all ones
		input_0   = 8'hFF;
		input_1   = 8'hFF;
		input_2   = 8'hFF;
		input_3   = dip_0;
		input_4   = 8'hFF;
		landscape = 1'b0;
		case (game)
			GAME_SPYHNT: begin
				input_0 = ~{service, 2'b00, controls.shift, 3'b000, coin};
				input_1 = ~{3'b000, controls.fire_a, controls.fire_c, controls.fire_e,
					controls.fire_b, controls.fire_d};
			end
			GAME_TURBO: begin
				input_0 = ~{service, 2'b00, controls.shift, 3'b000, coin};
				input_1 = ~{3'b000, controls.fire_e, controls.fire_d, controls.fire_c,
					controls.fire_b, controls.fire_a};
			end
			GAME_CRATER: begin
				landscape = 1'b1;
				input_0   = ~{service, 2'b00, controls.fire_a, controls.fire_e,
					controls.shift, 1'b0, coin};
				// Up and down steer the crosshair
				input_2   = ~{1'b0, controls.fire_b, 1'b0, controls.fire_c,
					controls.down, controls.up, 2'b00};
			end
			default: begin
			end
		endcase
	end

endmodule

/* logic/player_controls.sv */
// Keyboard and joystick controls
`include "arcade_consts.svh"

module player_controls (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic [10:0]       ps2_key,
	input  logic [`JOY_W-1:0] joy_1,
	input  logic [`JOY_W-1:0] joy_2,
	output arcade_pkg::ctrl_t controls,
	output logic              coin
);
	import arcade_pkg::*;

	logic       key_toggle_q;
	logic       key_event;
	logic       pressed;
	logic [7:0] code;

	// Keyboard button state per player
	ctrl_t btn_1;
	ctrl_t btn_2;
	logic  btn_coin_1;
	logic  btn_coin_2;

	ctrl_t ctrl_1;
	ctrl_t ctrl_2;

	assign pressed   = ps2_key[9];
	assign code      = ps2_key[7:0];
	assign key_event = ps2_key[10] != key_toggle_q;

	// ==================================================
	// Scan code decoder
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			key_toggle_q <= 1'b0;
			btn_1        <= '0;
			btn_2        <= '0;
			btn_coin_1   <= 1'b0;
			btn_coin_2   <= 1'b0;
		end else begin
			key_toggle_q <= ps2_key[10];
			if (key_event) begin
				case (code)
					`KEY_P1_UP:       btn_1.up     <= pressed;
					`KEY_P1_DOWN:     btn_1.down   <= pressed;
					`KEY_P1_LEFT:     btn_1.left   <= pressed;
					`KEY_P1_RIGHT:    btn_1.right  <= pressed;
					`KEY_P1_COIN,
					`KEY_P1_COIN_ALT: btn_coin_1   <= pressed;
					`KEY_P1_FIRE_A:   btn_1.fire_a <= pressed;
					`KEY_P1_FIRE_B:   btn_1.fire_b <= pressed;
					`KEY_P1_FIRE_C:   btn_1.fire_c <= pressed;
					`KEY_P1_FIRE_D:   btn_1.fire_d <= pressed;
					`KEY_P1_FIRE_E:   btn_1.fire_e <= pressed;
					// Shift is shared by both players
					`KEY_SHIFT: begin
						btn_1.shift <= pressed;
						btn_2.shift <= pressed;
					end
					`KEY_P2_COIN:     btn_coin_2   <= pressed;
					`KEY_P2_UP:       btn_2.up     <= pressed;
					`KEY_P2_DOWN:     btn_2.down   <= pressed;
					`KEY_P2_LEFT:     btn_2.left   <= pressed;
					`KEY_P2_RIGHT:    btn_2.right  <= pressed;
					`KEY_P2_FIRE_A:   btn_2.fire_a <= pressed;
					`KEY_P2_FIRE_B:   btn_2.fire_b <= pressed;
					`KEY_P2_FIRE_C:   btn_2.fire_c <= pressed;
					`KEY_P2_FIRE_D:   btn_2.fire_d <= pressed;
					default: begin
					end
				endcase
			end
		end
	end

	// ==================================================
	// Keyboard and joystick merge
	// ==================================================
	// Joystick bits 9:0 share the ctrl_t layout
	assign ctrl_1 = btn_1 | joy_1[`CTRL_W-1:0];
	assign ctrl_2 = btn_2 | joy_2[`CTRL_W-1:0];

	assign controls = ctrl_1 | ctrl_2;

	assign coin = btn_coin_1 | btn_coin_2 | joy_1[`JOY_COIN_BIT] | joy_2[`JOY_COIN_BIT];

endmodule

/* logic/reset_sequencer.sv */
// Game reset sequencer
`include "arcade_consts.svh"

module reset_sequencer (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic user_reset,
	input  logic rom_loaded,
	output logic game_reset
);

	localparam int CNT_W = $clog2(`RESET_PULSE_CYCLES);

	logic             reset_cause;
	logic [CNT_W-1:0] pulse_count;
	logic             pulse_hit;

	// Held in reset until the ROM is in place
	assign reset_cause = user_reset | ~rom_loaded;
	assign pulse_hit   = pulse_count == CNT_W'(1);

	// ==================================================
	// Late pulse counter
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pulse_count <= '1;
		end else if (reset_cause) begin
			pulse_count <= '1;
		end else if (pulse_count != '0) begin
			pulse_count <= pulse_count - 1'b1;
		end
	end

	// Second reset, one cycle wide, late after release
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_reset <= 1'b1;
		end else begin
			game_reset <= reset_cause | pulse_hit;
		end
	end

endmodule

/* logic/setup_loader.sv */
// Game select and DIP loader
`include "arcade_consts.svh"

module setup_loader (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic [7:0]            ioctl_index,
	input  logic [`DL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output arcade_pkg::game_e     game,
	output logic [7:0]            dip_0,
	output logic [7:0]            dip_1,
	output logic                  rom_loaded
);
	import arcade_pkg::*;

	logic [7:0] game_sel;
	logic       game_wr;
	logic       dip_wr;
	logic       rom_dl;
	logic [1:0] rom_dl_q;

	assign game_wr = ioctl_wr && (ioctl_index == `DL_INDEX_GAME);
	assign rom_dl  = ioctl_download && (ioctl_index == `DL_INDEX_ROM);

	// Banks 0 and 1 only
	assign dip_wr = ioctl_wr && (ioctl_index == `DL_INDEX_DIP)
		&& (ioctl_addr[`DL_ADDR_W-1:1] == '0);

	// Selection byte, decoded one edge after the write
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_sel <= 8'h00;
			game     <= GAME_SPYHNT;
		end else begin
			if (game_wr)
				game_sel <= ioctl_dout;
			case (game_sel)
				8'd0:    game <= GAME_SPYHNT;
				8'd1:    game <= GAME_TURBO;
				8'd2:    game <= GAME_CRATER;
				default: game <= GAME_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dip_0 <= 8'hFF;
			dip_1 <= 8'hFF;
		end else if (dip_wr) begin
			if (ioctl_addr[0])
				dip_1 <= ioctl_dout;
			else
				dip_0 <= ioctl_dout;
		end
	end

	// ROM download end, sticky until reset
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_dl_q   <= 2'b00;
			rom_loaded <= 1'b0;
		end else begin
			rom_dl_q <= {rom_dl_q[0], rom_dl};
			if (rom_dl_q[1] && !rom_dl_q[0])
				rom_loaded <= 1'b1;
		end
	end

endmodule

/* project.f */
+incdir+logic
logic/arcade_pkg.sv
logic/player_controls.sv
logic/setup_loader.sv
logic/reset_sequencer.sv
logic/input_port_map.sv
logic/arcade_inputs.sv
tb/tb_arcade_inputs.sv

/* run.sh */
#!/bin/sh
# Build and run the input block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_arcade_inputs \
	-Mdir obj_dir \
	-o tb_arcade_inputs

# Simulation status is judged from the log below
./obj_dir/tb_arcade_inputs 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi

/* tb/tb_arcade_inputs.sv */
// Input block testbench
`include "arcade_consts.svh"

module tb_arcade_inputs;
	timeunit 1ns;
	timeprecision 1ps;
	import arcade_pkg::*;

	logic                  clk_sys;
	logic                  arst_n;
	logic [10:0]           ps2_key;
	logic [`JOY_W-1:0]     joy_1;
	logic [`JOY_W-1:0]     joy_2;
	logic                  ioctl_download;
	logic                  ioctl_wr;
	logic [7:0]            ioctl_index;
	logic [`DL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic                  user_reset;
	logic [7:0]            input_0;
	logic [7:0]            input_1;
	logic [7:0]            input_2;
	logic [7:0]            input_3;
	logic [7:0]            input_4;
	logic                  landscape;
	logic                  game_reset;

	// Reference model state
	ctrl_t      kb_1;
	ctrl_t      kb_2;
	logic [1:0] kb_coin;
	game_e      m_game;
	logic [7:0] m_dip_0;
	logic [7:0] m_dip_1;
	logic       rom_done;
	integer     seed;

	ctrl_t      exp_ctrl;
	logic       exp_coin;
	logic       service;
	logic [7:0] exp_input_0;
	logic [7:0] exp_input_1;
	logic [7:0] exp_input_2;
	logic [7:0] exp_input_3;
	logic [7:0] exp_input_4;
	logic       exp_landscape;

	arcade_inputs uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Expected port values
	// ==================================================
	always_comb begin
		exp_ctrl      = kb_1 | kb_2 | joy_1[`CTRL_W-1:0] | joy_2[`CTRL_W-1:0];
		exp_coin      = (|kb_coin) | joy_1[`JOY_COIN_BIT] | joy_2[`JOY_COIN_BIT];
		service       = m_dip_1[0];
		exp_input_0   = 8'hFF;
		exp_input_1   = 8'hFF;
		exp_input_2   = 8'hFF;
		exp_input_3   = m_dip_0;
		exp_input_4   = 8'hFF;
		exp_landscape = 1'b0;
		case (m_game)
			GAME_SPYHNT: begin
				exp_input_0 = ~{service, 2'b00, exp_ctrl.shift, 3'b000, exp_coin};
				exp_input_1 = ~{3'b000, exp_ctrl.fire_a, exp_ctrl.fire_c, exp_ctrl.fire_e,
					exp_ctrl.fire_b, exp_ctrl.fire_d};
			end
			GAME_TURBO: begin
				exp_input_0 = ~{service, 2'b00, exp_ctrl.shift, 3'b000, exp_coin};
				exp_input_1 = ~{3'b000, exp_ctrl.fire_e, exp_ctrl.fire_d, exp_ctrl.fire_c,
					exp_ctrl.fire_b, exp_ctrl.fire_a};
			end
			GAME_CRATER: begin
				exp_landscape = 1'b1;
				exp_input_0   = ~{service, 2'b00, exp_ctrl.fire_a, exp_ctrl.fire_e,
					exp_ctrl.shift, 1'b0, exp_coin};
				exp_input_2   = ~{1'b0, exp_ctrl.fire_b, 1'b0, exp_ctrl.fire_c,
					exp_ctrl.down, exp_ctrl.up, 2'b00};
			end
			default: begin
			end
		endcase
	end

	task fail_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task report_mismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
		fail_run($sformatf("mismatch %s: got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	port_0: assert property (@(posedge clk_sys) disable iff (!arst_n) input_0 == exp_input_0)
		else report_mismatch("input_0", $sampled(input_0), $sampled(exp_input_0));
	port_1: assert property (@(posedge clk_sys) disable iff (!arst_n) input_1 == exp_input_1)
		else report_mismatch("input_1", $sampled(input_1), $sampled(exp_input_1));
	port_2: assert property (@(posedge clk_sys) disable iff (!arst_n) input_2 == exp_input_2)
		else report_mismatch("input_2", $sampled(input_2), $sampled(exp_input_2));
	port_3: assert property (@(posedge clk_sys) disable iff (!arst_n) input_3 == exp_input_3)
		else report_mismatch("input_3", $sampled(input_3), $sampled(exp_input_3));
	port_4: assert property (@(posedge clk_sys) disable iff (!arst_n) input_4 == exp_input_4)
		else report_mismatch("input_4", $sampled(input_4), $sampled(exp_input_4));
	orient: assert property (@(posedge clk_sys) disable iff (!arst_n)
		landscape == exp_landscape)
		else report_mismatch("landscape", 8'($sampled(landscape)), 8'($sampled(exp_landscape)));
	// Held while the ROM is missing or one edge after user reset
	reset_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		($past(user_reset) || !rom_done) |-> game_reset)
		else report_mismatch("game_reset", 8'($sampled(game_reset)), 8'h01);

	// Scan code table for the button model
	task apply_key(input logic [7:0] code, input logic pressed);
		case (code)
			`KEY_P1_UP:       kb_1.up <= pressed;
			`KEY_P1_DOWN:     kb_1.down <= pressed;
			`KEY_P1_LEFT:     kb_1.left <= pressed;
			`KEY_P1_RIGHT:    kb_1.right <= pressed;
			`KEY_P1_COIN,
			`KEY_P1_COIN_ALT: kb_coin[0] <= pressed;
			`KEY_P1_FIRE_A:   kb_1.fire_a <= pressed;
			`KEY_P1_FIRE_B:   kb_1.fire_b <= pressed;
			`KEY_P1_FIRE_C:   kb_1.fire_c <= pressed;
			`KEY_P1_FIRE_D:   kb_1.fire_d <= pressed;
			`KEY_P1_FIRE_E:   kb_1.fire_e <= pressed;
			`KEY_SHIFT:       kb_1.shift <= pressed;
			`KEY_P2_COIN:     kb_coin[1] <= pressed;
			`KEY_P2_UP:       kb_2.up <= pressed;
			`KEY_P2_DOWN:     kb_2.down <= pressed;
			`KEY_P2_FIRE_B:   kb_2.fire_b <= pressed;
			default: begin
			end
		endcase
	endtask

	task send_key(input logic [7:0] code, input logic pressed);
		ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
		@(posedge clk_sys);
		apply_key(code, pressed);
		@(posedge clk_sys);
	endtask

	task tap_key(input logic [7:0] code);
		send_key(code, 1'b1);
		send_key(code, 1'b0);
	endtask

	task write_byte(input logic [7:0] index, input logic [`DL_ADDR_W-1:0] addr,
		input logic [7:0] data);
		ioctl_wr    <= 1'b1;
		ioctl_index <= index;
		ioctl_addr  <= addr;
		ioctl_dout  <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		if (index == `DL_INDEX_DIP && addr == '0)
			m_dip_0 <= data;
		else if (index == `DL_INDEX_DIP && addr == `DL_ADDR_W'(1))
			m_dip_1 <= data;
		@(posedge clk_sys);
		// Game decode lands one edge after the byte
		if (index == `DL_INDEX_GAME) begin
			case (data)
				8'd0:    m_game <= GAME_SPYHNT;
				8'd1:    m_game <= GAME_TURBO;
				8'd2:    m_game <= GAME_CRATER;
				default: m_game <= GAME_NONE;
			endcase
		end
	endtask

	task drive_random_joy(input int count);
		repeat (count) begin
			joy_1 <= $random(seed);
			joy_2 <= $random(seed);
			@(posedge clk_sys);
		end
		joy_1 <= '0;
		joy_2 <= '0;
		@(posedge clk_sys);
	endtask

	task end_rom_download;
		ioctl_download <= 1'b1;
		for (int i = 0; i < 4; i++)
			write_byte(`DL_INDEX_ROM, `DL_ADDR_W'(i), 8'(i * 37));
		ioctl_download <= 1'b0;
		rom_done       <= 1'b1;
		@(posedge clk_sys);
	endtask

	task wait_game_reset(input logic level, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > limit)
				fail_run("timeout waiting for game_reset to change level");
		end while (game_reset !== level);
	endtask

	task check_late_pulse;
		int n;
		wait_game_reset(1'b0, 10, n);
		wait_game_reset(1'b1, 2 * `RESET_PULSE_CYCLES, n);
		// Registered fall lags the release of the reset causes by one edge
		assert (n == `RESET_PULSE_CYCLES - 2)
			else report_mismatch("pulse_delay", 8'(n), 8'(`RESET_PULSE_CYCLES - 2));
		repeat (4) begin
			@(negedge clk_sys);
			assert (game_reset == 1'b0)
				else report_mismatch("game_reset", 8'(game_reset), 8'h00);
		end
		@(posedge clk_sys);
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		int n;
		seed           = 30359;
		arst_n         = 1'b0;
		ps2_key        = '0;
		joy_1          = '0;
		joy_2          = '0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		user_reset     = 1'b0;
		kb_1           = '0;
		kb_2           = '0;
		kb_coin        = '0;
		m_game         = GAME_SPYHNT;
		m_dip_0        = 8'hFF;
		m_dip_1        = 8'hFF;
		rom_done       = 1'b0;
		repeat (3) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(posedge clk_sys);

		// Spy Hunter keys
		tap_key(`KEY_P1_FIRE_A);
		tap_key(`KEY_SHIFT);
		tap_key(`KEY_P1_COIN);
		tap_key(`KEY_P1_COIN_ALT);
		tap_key(8'h00);

		// Joysticks on top of held keys
		send_key(`KEY_P1_FIRE_B, 1'b1);
		send_key(`KEY_P2_UP, 1'b1);
		drive_random_joy(24);
		joy_1 <= 32'h0000_0400;
		@(posedge clk_sys);
		joy_1 <= '0;
		joy_2 <= 32'h0000_0400;
		@(posedge clk_sys);
		joy_2 <= '0;
		@(posedge clk_sys);
		tap_key(`KEY_P2_COIN);
		send_key(`KEY_P1_FIRE_B, 1'b0);
		send_key(`KEY_P2_UP, 1'b0);

		// Turbo Tag, Crater, then an unknown game
		write_byte(`DL_INDEX_GAME, '0, 8'd1);
		tap_key(`KEY_P1_FIRE_E);
		tap_key(`KEY_P1_FIRE_D);
		drive_random_joy(8);
		write_byte(`DL_INDEX_GAME, '0, 8'd2);
		tap_key(`KEY_P1_UP);
		tap_key(`KEY_P2_DOWN);
		tap_key(`KEY_P2_FIRE_B);
		tap_key(`KEY_P1_FIRE_C);
		tap_key(`KEY_P1_FIRE_A);
		tap_key(`KEY_P1_FIRE_E);
		drive_random_joy(8);
		write_byte(`DL_INDEX_GAME, '0, 8'd7);
		drive_random_joy(8);

		// DIP banks under Spy Hunter
		write_byte(`DL_INDEX_GAME, '0, 8'd0);
		write_byte(`DL_INDEX_DIP, '0, 8'h5A);
		write_byte(`DL_INDEX_DIP, `DL_ADDR_W'(1), 8'h00);
		write_byte(`DL_INDEX_DIP, `DL_ADDR_W'(1), 8'h01);
		write_byte(`DL_INDEX_DIP, `DL_ADDR_W'(2), 8'h00);
		tap_key(`KEY_SHIFT);

		// Late reset after the ROM download
		end_rom_download();
		check_late_pulse();

		// User reset and a second late pulse
		user_reset <= 1'b1;
		wait_game_reset(1'b1, 4, n);
		@(posedge clk_sys);
		repeat (3) @(posedge clk_sys);
		user_reset <= 1'b0;
		check_late_pulse();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
